// ==== vlog.f ====
source/lane_pkg.sv
source/lane_cmd_port.sv
source/lane_regfile.sv
source/operand_network.sv
source/lane_alu.sv
source/vector_lane.sv
test/vector_lane_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the lane testbench with Verilator, run it and look for the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module vector_lane_tb -f vlog.f -o vector_lane_sim

./obj_dir/vector_lane_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== test/vector_lane_tb.sv ====
// Testbench for the vector lane; drives Wishbone writes and checks each result against a model
`timescale 1ns/1ns

module vector_lane_tb;
	import lane_pkg::*;

	localparam int NUM_REGS   = 16;
	localparam int N_ZERO     = NUM_REGS;			// MOV from every register
	localparam int N_SCALAR   = 4 * 3 + 3;
	localparam int N_DENSE    = 60;
	localparam int N_LDST     = 4 * 4;
	localparam int N_SPARSE   = 40;
	localparam int N_WRITES   = N_ZERO + N_SCALAR + N_DENSE + N_LDST + N_SPARSE;
	localparam int MAX_CYCLES = 4 * N_WRITES + 50;

	logic    clk;
	logic    arst_n;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	logic    wb_adr;
	data_t   wb_dat_w;
	logic    wb_ack;
	logic    res_valid;
	result_t res;

	data_t   regs_model [NUM_REGS];
	data_t   scalar_model;
	result_t exp_q [$];			// Expected results in issue order
	result_t exp_r;
	int      seed;
	int      mismatches;
	int      other_errors;
	int      cycle_count;
	logic    sparse;

	vector_lane #(.NUM_REGS(NUM_REGS)) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack),
		.res_valid (res_valid),
		.res       (res)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic data_t next_rand();
		return $random(seed);
	endfunction

	function automatic logic updates_reg(input opcode_t op);
		return (op == OP_MOV) || (op == OP_ADD) || (op == OP_SUB) || (op == OP_MAD);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic result_t expected_result(input lane_instr_t ins, input data_t scalar);
		data_t [3:0] ports;
		data_t [2:0] src;
		result_t     r;
		logic [1:0]  rot;
		for (int p = 0; p < 4; p++) begin
			ports[p] = regs_model[ins.rd_idx[p]];	// Model is already in issue order
		end
		for (int s = 0; s < 3; s++) begin
			if (ins.src_sel[s] < 3'd4) begin
				src[s] = ports[ins.src_sel[s][1:0]];
			end else if (ins.src_sel[s] == SEL_SCALAR) begin
				src[s] = scalar;
			end else begin
				src[s] = '0;
			end
		end
		r     = '0;
		r.op  = ins.op;
		r.dst = ins.dst;
		case (ins.op)
			OP_MOV:  r.data = src[0];
			OP_ADD:  r.data = src[0] + src[1];
			OP_SUB:  r.data = src[0] - src[1];
			OP_MAD:  r.data = src[0] * src[1] + src[2];
			default: r.data = '0;
		endcase
		if (ins.op == OP_LDST) begin
			rot       = ins.src_sel[0][1:0];
			r.address = ports[rot];
			r.stride  = ports[rot + 2'd1];
			r.length  = ports[rot + 2'd2];
		end
		return r;
	endfunction

	function automatic lane_instr_t rand_instr(input logic [3:0] idx_mask);
		lane_instr_t ins;
		data_t       r;
		data_t       r2;
		r       = next_rand();
		r2      = next_rand();
		ins.op  = OP_MOV + opcode_t'(r[1:0]);	// MOV, ADD, SUB or MAD
		ins.dst = r[5:2] & idx_mask;
		for (int p = 0; p < 4; p++) begin
			ins.rd_idx[p] = r[9 + 4 * p +: 4] & idx_mask;
		end
		for (int s = 0; s < 3; s++) begin
			ins.src_sel[s] = r2[3 * s +: 3];
		end
		return ins;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Wishbone driver
	////////////////////////////////////////////////////////////////////////////

	task automatic wb_write(input logic adr, input data_t dat);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		@(posedge clk);
		while (!wb_ack) begin
			@(posedge clk);
		end
	endtask

	task automatic bus_idle(input int cycles);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic load_scalar(input data_t v);
		scalar_model = v;
		wb_write(1'b0, v);
	endtask

	task automatic issue_instr(input lane_instr_t ins);
		result_t want;
		data_t   r;
		r = next_rand();
		if (sparse && r[0]) begin
			bus_idle(1 + int'(r[4]));		// Gap of one or two cycles
		end
		want = expected_result(ins, scalar_model);
		exp_q.push_back(want);
		if (updates_reg(ins.op)) begin
			regs_model[ins.dst] = want.data;
		end
		wb_write(1'b1, data_t'(ins));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checker
	////////////////////////////////////////////////////////////////////////////

	task automatic check_field(input string name, input data_t got, input data_t want);
		assert (got === want) else begin
			mismatches++;
			$display("mismatch %s: got 0x%08h expected 0x%08h", name, got, want);
		end
	endtask

	always @(posedge clk) begin
		// Zero wait state ack in the strobe cycle
		assert (wb_ack === (wb_cyc & wb_stb)) else begin
			mismatches++;
			$display("mismatch wb_ack: got 0x%0h expected 0x%0h", wb_ack, wb_cyc & wb_stb);
		end
		if (arst_n && res_valid) begin
			assert (exp_q.size() != 0) else begin
				other_errors++;
				$display("result arrived with no instruction in flight, dst %0d", res.dst);
			end
			if (exp_q.size() != 0) begin
				exp_r = exp_q.pop_front();
				check_field("op", data_t'(res.op), data_t'(exp_r.op));
				check_field("dst", data_t'(res.dst), data_t'(exp_r.dst));
				check_field("data", res.data, exp_r.data);
				check_field("address", res.address, exp_r.address);
				check_field("stride", res.stride, exp_r.stride);
				check_field("length", res.length, exp_r.length);
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		other_errors++;
		$display("timeout after %0d cycles with %0d results pending", cycle_count, exp_q.size());
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		lane_instr_t ins;
		data_t       v;
		logic [3:0]  d;
		arst_n       = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 1'b0;
		wb_dat_w     = '0;
		seed         = 32'h1618_3af6;
		mismatches   = 0;
		other_errors = 0;
		sparse       = 1'b0;
		scalar_model = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			regs_model[i] = '0;
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);				// Nothing may come out yet

		// Every register reads zero after reset
		for (int i = 0; i < N_ZERO; i++) begin
			ins = '0;
			ins.op = OP_MOV;
			ins.dst = 4'(i);
			ins.rd_idx[i % 4] = 4'(i);
			ins.src_sel[0] = 3'(i % 4);
			issue_instr(ins);
		end

		// Scalar into a register, then read back through each port
		for (int k = 0; k < 4; k++) begin
			v = next_rand();
			d = v[7:4];
			load_scalar(v);
			ins = '0;
			ins.op = OP_MOV;
			ins.dst = d;
			ins.src_sel[0] = SEL_SCALAR;
			issue_instr(ins);
			ins = rand_instr(4'hf);
			ins.op = OP_MOV;
			ins.dst = d + 4'd1;
			ins.rd_idx[k] = d;
			ins.src_sel[0] = 3'(k);
			issue_instr(ins);
		end
		for (int z = 5; z < 8; z++) begin
			ins = rand_instr(4'hf);
			ins.op = OP_MOV;
			ins.src_sel[0] = 3'(z);				// Zero select
			issue_instr(ins);
		end

		// Dense random traffic on few registers to stress forwarding
		for (int n = 0; n < N_DENSE; n++) begin
			v = next_rand();
			if (v[2:0] == 3'd0) begin
				load_scalar(next_rand());
			end else begin
				issue_instr(rand_instr(4'h3));
			end
		end

		// LDST right behind the two producers of its ports
		for (int r = 0; r < 4; r++) begin
			v = next_rand();
			load_scalar(v);
			ins = '0;
			ins.op = OP_MOV;
			ins.dst = 4'd1;
			ins.src_sel[0] = SEL_SCALAR;
			issue_instr(ins);
			ins = '0;
			ins.op = OP_ADD;
			ins.dst = 4'd2;
			ins.rd_idx[0] = 4'd1;
			ins.src_sel[0] = 3'd0;
			ins.src_sel[1] = SEL_SCALAR;
			issue_instr(ins);
			ins = rand_instr(4'h3);
			ins.op = OP_LDST;
			for (int p = 0; p < 4; p++) begin
				ins.rd_idx[p] = 4'((p + 1) % 4);
			end
			ins.src_sel[0] = {v[8], 2'(r)};		// Upper bit must not matter
			issue_instr(ins);
		end

		// Same kind of traffic with random gaps
		sparse = 1'b1;
		for (int n = 0; n < N_SPARSE; n++) begin
			issue_instr(rand_instr(4'hf));
		end
		bus_idle(1);

		for (int w = 0; (w < 10) && (exp_q.size() != 0); w++) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);				// Catch any stray result
		assert (exp_q.size() == 0) else begin
			other_errors++;
			$display("%0d expected results never came out", exp_q.size());
		end
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if ((mismatches == 0) && (other_errors == 0)) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== source/vector_lane.sv ====
// Top of one vector lane; Wishbone issue, register read, operand network, execute and write-back
`timescale 1ns/1ns

module vector_lane #(
	parameter int NUM_REGS = 16
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic               wb_adr,
	input  lane_pkg::data_t    wb_dat_w,
	output logic               wb_ack,
	output logic               res_valid,
	output lane_pkg::result_t  res
);
	import lane_pkg::*;

	logic     issue_valid;
	issue_t   issue;
	logic     read_valid;
	read_t    rd;
	logic     op_valid;
	operand_t opnd;
	logic     alu_valid;
	result_t  alu_fwd;

	lane_cmd_port cmd_port_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_ack      (wb_ack),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	// Write-back comes from the result register
	lane_regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.wr_valid    (res_valid),
		.wr          (res),
		.read_valid  (read_valid),
		.rd          (rd)
	);

	operand_network #(.NUM_REGS(NUM_REGS)) network_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.read_valid (read_valid),
		.rd         (rd),
		.alu_valid  (alu_valid),
		.alu_fwd    (alu_fwd),
		.res_valid  (res_valid),
		.res        (res),
		.op_valid   (op_valid),
		.opnd       (opnd)
	);

	lane_alu alu_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.op_valid  (op_valid),
		.opnd      (opnd),
		.alu_valid (alu_valid),
		.alu_fwd   (alu_fwd),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

// ==== source/lane_alu.sv ====
// Execute stage; computes MOV/ADD/SUB/MAD data, passes the LD/ST descriptor and registers the result
`timescale 1ns/1ns

module lane_alu (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                op_valid,
	input  lane_pkg::operand_t  opnd,
	output logic                alu_valid,
	output lane_pkg::result_t   alu_fwd,		// To the forwarding path
	output logic                res_valid,
	output lane_pkg::result_t   res
);
	import lane_pkg::*;

	result_t res_next;
	data_t   product;

	assign product = opnd.src[0] * opnd.src[1];	// Low 32 bits only

	always_comb begin
		res_next.op      = opnd.op;
		res_next.dst     = opnd.dst;
		res_next.address = opnd.address;
		res_next.stride  = opnd.stride;
		res_next.length  = opnd.length;
		case (opnd.op)
			OP_MOV:  res_next.data = opnd.src[0];
			OP_ADD:  res_next.data = opnd.src[0] + opnd.src[1];
			OP_SUB:  res_next.data = opnd.src[0] - opnd.src[1];
			OP_MAD:  res_next.data = product + opnd.src[2];
			default: res_next.data = '0;		// NOP, LDST
		endcase
	end

	assign alu_valid = op_valid;
	assign alu_fwd   = res_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= op_valid;
		end
	end

	always_ff @(posedge clk) begin
		res <= res_next;
	end

endmodule

// ==== source/operand_network.sv ====
// Operand network stage; forwards in-flight results, routes ALU operands and rotates the LD/ST descriptor
`timescale 1ns/1ns

module operand_network #(
	parameter int NUM_REGS = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                read_valid,
	input  lane_pkg::read_t     rd,
	input  logic                alu_valid,
	input  lane_pkg::result_t   alu_fwd,		// ALU result before its register
	input  logic                res_valid,
	input  lane_pkg::result_t   res,
	output logic                op_valid,
	output lane_pkg::operand_t  opnd
);
	import lane_pkg::*;

	data_t [3:0] fwd;			// Read ports after forwarding
	data_t [2:0] src_next;
	data_t       address_next;
	data_t       stride_next;
	data_t       length_next;
	logic        alu_wr;
	logic        res_wr;
	logic        is_ldst;
	logic [1:0]  rot0;
	logic [1:0]  rot1;
	logic [1:0]  rot2;

	function automatic data_t route(input sel_t sel, input data_t [3:0] ports,
	                                input data_t scalar);
		data_t val;
		case (sel)
			3'd0, 3'd1, 3'd2, 3'd3: val = ports[sel[1:0]];
			SEL_SCALAR:             val = scalar;
			default:                val = '0;	// 5..7 give zero
		endcase
		return val;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////////////////////

	assign alu_wr = alu_valid & op_writes(alu_fwd.op);
	assign res_wr = res_valid & op_writes(res.op);

	always_comb begin
		for (int p = 0; p < 4; p++) begin
			if (alu_wr && (alu_fwd.dst == rd.instr.rd_idx[p])) begin
				fwd[p] = alu_fwd.data;		// Youngest result first
			end else if (res_wr && (res.dst == rd.instr.rd_idx[p])) begin
				fwd[p] = res.data;
			end else begin
				fwd[p] = rd.port[p];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand routing and descriptor
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int s = 0; s < 3; s++) begin
			src_next[s] = route(rd.instr.src_sel[s], fwd, rd.scalar);
		end
	end

	assign is_ldst = (rd.instr.op == OP_LDST);
	assign rot0    = rd.instr.src_sel[0][1:0];
	assign rot1    = rot0 + 2'd1;				// Wraps mod 4
	assign rot2    = rot0 + 2'd2;

	assign address_next = is_ldst ? fwd[rot0] : '0;
	assign stride_next  = is_ldst ? fwd[rot1] : '0;
	assign length_next  = is_ldst ? fwd[rot2] : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= read_valid;
		end
	end

	always_ff @(posedge clk) begin
		opnd.op      <= rd.instr.op;
		opnd.dst     <= rd.instr.dst;
		opnd.src     <= src_next;
		opnd.address <= address_next;
		opnd.stride  <= stride_next;
		opnd.length  <= length_next;
	end

	opcode_defined: assert property (
		@(posedge clk) disable iff (!arst_n)
		read_valid |-> (rd.instr.op <= OP_LDST)
	) else $error("undefined opcode %0d in operand network", rd.instr.op);

	// A forwarded destination must be one the register file really holds
	fwd_dst_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		alu_wr |-> (int'(alu_fwd.dst) < NUM_REGS)
	) else $error("forwarded dst beyond NUM_REGS");

endmodule

// ==== source/lane_regfile.sv ====
// Register-read stage; lane register file with four registered read ports and write-through
`timescale 1ns/1ns

module lane_regfile #(
	parameter int NUM_REGS = 16
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  lane_pkg::issue_t   issue,
	input  logic               wr_valid,
	input  lane_pkg::result_t  wr,
	output logic               read_valid,
	output lane_pkg::read_t    rd
);
	import lane_pkg::*;

	data_t       regs [NUM_REGS];
	data_t [3:0] port_next;
	logic        wr_en;

	assign wr_en = wr_valid & op_writes(wr.op);	// NOP and LDST leave regs alone

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr.dst] <= wr.data;
		end
	end

	// Same-cycle write to the read index returns the new word
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			if (wr_en && (wr.dst == issue.instr.rd_idx[p])) begin
				port_next[p] = wr.data;
			end else begin
				port_next[p] = regs[issue.instr.rd_idx[p]];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= issue_valid;
		end
	end

	always_ff @(posedge clk) begin
		rd.instr  <= issue.instr;
		rd.scalar <= issue.scalar;
		rd.port   <= port_next;
	end

	index_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(!wr_en || (int'(wr.dst) < NUM_REGS)) &&
		(!issue_valid || ((int'(issue.instr.rd_idx[0]) < NUM_REGS) &&
			(int'(issue.instr.rd_idx[1]) < NUM_REGS) &&
			(int'(issue.instr.rd_idx[2]) < NUM_REGS) &&
			(int'(issue.instr.rd_idx[3]) < NUM_REGS)))
	) else $error("register index beyond NUM_REGS");

endmodule

// ==== source/lane_cmd_port.sv ====
// Wishbone classic write port of the lane; loads the scalar and issues instructions
`timescale 1ns/1ns

module lane_cmd_port (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic              wb_adr,		// 0 scalar, 1 instruction
	input  lane_pkg::data_t   wb_dat_w,
	output logic              wb_ack,
	output logic              issue_valid,
	output lane_pkg::issue_t  issue
);
	import lane_pkg::*;

	data_t scalar_q;
	logic  wb_access;
	logic  scalar_wr;

	assign wb_access = wb_cyc & wb_stb;
	assign wb_ack    = wb_access;				// Zero wait state, reads too
	assign scalar_wr = wb_access & wb_we & ~wb_adr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scalar_q <= '0;
		end else if (scalar_wr) begin
			scalar_q <= wb_dat_w;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Issue
	////////////////////////////////////////////////////////////////////////////

	// NOPs issue like any other instruction
	assign issue_valid  = wb_access & wb_we & wb_adr;
	assign issue.instr  = lane_instr_t'(wb_dat_w);
	assign issue.scalar = scalar_q;			// Paired with current scalar

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	ack_needs_strobe: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(wb_ack) |-> (wb_cyc && wb_stb)
	) else $error("wb_ack rose without cyc and stb");

endmodule

// ==== source/lane_pkg.sv ====
// Lane data, instruction and stage payload types plus opcodes, imported by every lane RTL file
package lane_pkg;

	typedef logic [31:0] data_t;		// Lane data word
	typedef logic [2:0]  opcode_t;
	typedef logic [3:0]  reg_idx_t;		// Register index, up to 16 registers
	typedef logic [2:0]  sel_t;			// Operand select

	localparam opcode_t OP_NOP  = 3'd0;
	localparam opcode_t OP_MOV  = 3'd1;
	localparam opcode_t OP_ADD  = 3'd2;
	localparam opcode_t OP_SUB  = 3'd3;
	localparam opcode_t OP_MAD  = 3'd4;
	localparam opcode_t OP_LDST = 3'd5;	// 6 and 7 are undefined

	localparam sel_t SEL_SCALAR = 3'd4;	// 0..3 read port, 5..7 zero

	// op in [31:29], dst in [28:25], rd_idx in [24:9], src_sel in [8:0]
	// src_sel[0][1:0] doubles as the load/store descriptor rotation
	typedef struct packed {
		opcode_t             op;
		reg_idx_t            dst;
		reg_idx_t [3:0]      rd_idx;
		sel_t [2:0]          src_sel;
	} lane_instr_t;

	typedef struct packed {
		lane_instr_t         instr;
		data_t               scalar;	// Scalar latched at issue
	} issue_t;

	typedef struct packed {
		lane_instr_t         instr;
		data_t               scalar;
		data_t [3:0]         port;		// Register file read ports
	} read_t;

	typedef struct packed {
		opcode_t             op;
		reg_idx_t            dst;
		data_t [2:0]         src;		// ALU operands 1 to 3
		data_t               address;
		data_t               stride;
		data_t               length;
	} operand_t;

	typedef struct packed {
		opcode_t             op;
		reg_idx_t            dst;
		data_t               data;
		data_t               address;
		data_t               stride;
		data_t               length;
	} result_t;

	function automatic logic op_writes(input opcode_t op);
		return (op == OP_MOV) || (op == OP_ADD) || (op == OP_SUB) || (op == OP_MAD);
	endfunction

endpackage
